// ==== hw/trivium_pkg.sv ====
package trivium_pkg;

    // key and iv widths.
    localparam int KEY_BITS = 80;
    localparam int IV_BITS = 80;

    // full cipher state.
    localparam int STATE_BITS = 288;

    // register sizes, a at the bottom of the state.
    localparam int A_BITS = 93;  // s1..s93.
    localparam int B_BITS = 84;  // s94..s177.
    localparam int C_BITS = 111; // s178..s288.

    // initialisation rounds before the first keystream bit.
    localparam int SETUP_ROUNDS = 1152;

    typedef logic [KEY_BITS-1:0] key_t;
    typedef logic [IV_BITS-1:0] iv_t;

    // index 0 of each register is its first stage.
    typedef struct packed {
        logic [C_BITS-1:0] c;
        logic [B_BITS-1:0] b;
        logic [A_BITS-1:0] a;
    } regs_t;

    // flat view uses bit n-1 for stage sn of the spec.
    typedef union packed {
        logic [STATE_BITS-1:0] flat;
        regs_t regs;
    } trivium_state_u;

endpackage

// ==== hw/trivium_round.sv ====
`timescale 1ns/1ps

module trivium_round #(
    parameter int STEP_BITS = 64
) (
    input trivium_pkg::trivium_state_u cur,
    output trivium_pkg::trivium_state_u next_state,
    output logic [STEP_BITS-1:0] z
);

    // tap positions, spec numbering s1..s288.
    localparam int T1_LIN0 = 66;
    localparam int T1_LIN1 = 93;
    localparam int T1_AND0 = 91;
    localparam int T1_AND1 = 92;
    localparam int T1_XOR = 171;

    localparam int T2_LIN0 = 162;
    localparam int T2_LIN1 = 177;
    localparam int T2_AND0 = 175;
    localparam int T2_AND1 = 176;
    localparam int T2_XOR = 264;

    localparam int T3_LIN0 = 243;
    localparam int T3_LIN1 = 288;
    localparam int T3_AND0 = 286;
    localparam int T3_AND1 = 287;
    localparam int T3_XOR = 69;

    wire [STEP_BITS-1:0] t1;
    wire [STEP_BITS-1:0] t2;
    wire [STEP_BITS-1:0] t3;
    wire [STEP_BITS-1:0] fb_a; // feedback into a, oldest round in the top bit.
    wire [STEP_BITS-1:0] fb_b;
    wire [STEP_BITS-1:0] fb_c;

    // taps stay clear of fresh feedback only up to 66 rounds.
    if (STEP_BITS < 1 || STEP_BITS > 64) begin : g_bad_step
        $error("trivium_round: STEP_BITS must be in 1..64");
    end

    // round k reads every tap k stages earlier.
    for (genvar k = 0; k < STEP_BITS; k++) begin : g_round
        assign t1[k] = cur.flat[T1_LIN0-1-k] ^ cur.flat[T1_LIN1-1-k];
        assign t2[k] = cur.flat[T2_LIN0-1-k] ^ cur.flat[T2_LIN1-1-k];
        assign t3[k] = cur.flat[T3_LIN0-1-k] ^ cur.flat[T3_LIN1-1-k];

        assign fb_b[STEP_BITS-1-k] = t1[k]
            ^ (cur.flat[T1_AND0-1-k] & cur.flat[T1_AND1-1-k])
            ^ cur.flat[T1_XOR-1-k];
        assign fb_c[STEP_BITS-1-k] = t2[k]
            ^ (cur.flat[T2_AND0-1-k] & cur.flat[T2_AND1-1-k])
            ^ cur.flat[T2_XOR-1-k];
        assign fb_a[STEP_BITS-1-k] = t3[k]
            ^ (cur.flat[T3_AND0-1-k] & cur.flat[T3_AND1-1-k])
            ^ cur.flat[T3_XOR-1-k];
    end

    assign z = t1 ^ t2 ^ t3; // bit 0 is the earliest round.

    // each register moves up by STEP_BITS stages.
    always_comb begin
        next_state.regs.a = {cur.regs.a[trivium_pkg::A_BITS-STEP_BITS-1:0], fb_a};
        next_state.regs.b = {cur.regs.b[trivium_pkg::B_BITS-STEP_BITS-1:0], fb_b};
        next_state.regs.c = {cur.regs.c[trivium_pkg::C_BITS-STEP_BITS-1:0], fb_c};
    end

endmodule

// ==== hw/trivium_state.sv ====
`timescale 1ns/1ps

module trivium_state #(
    parameter int STEP_BITS = 64
) (
    input logic clk,
    input logic rst,
    input logic load,
    input logic advance,
    input logic emit,
    input trivium_pkg::key_t key,
    input trivium_pkg::iv_t iv,
    input trivium_pkg::trivium_state_u next_state,
    input logic [STEP_BITS-1:0] z,
    output trivium_pkg::trivium_state_u cur,
    output logic [STEP_BITS-1:0] keystream,
    output logic keystream_valid
);

    trivium_pkg::trivium_state_u load_val;

    // key into a, iv into b, top three stages of c set.
    always_comb begin
        load_val.regs.a = '0;
        load_val.regs.a[trivium_pkg::KEY_BITS-1:0] = key;
        load_val.regs.b = '0;
        load_val.regs.b[trivium_pkg::IV_BITS-1:0] = iv;
        load_val.regs.c = '0;
        load_val.regs.c[trivium_pkg::C_BITS-1 -: 3] = 3'b111;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cur <= '0;
        end else if (load) begin
            cur <= load_val;
        end else if (advance) begin
            cur <= next_state;
        end
    end

    // word holds between emits.
    always_ff @(posedge clk) begin
        if (rst) begin
            keystream <= '0;
            keystream_valid <= 1'b0;
        end else begin
            keystream_valid <= emit;
            if (emit) begin
                keystream <= z;
            end
        end
    end

    // the controller must never ask for both on one edge.
    a_no_load_and_advance: assert property (
        @(posedge clk) disable iff (rst) !(load && advance)
    ) else $error("trivium_state: load and advance together");

endmodule

// ==== hw/trivium_ctrl.sv ====
`timescale 1ns/1ps

module trivium_ctrl #(
    parameter int STEP_BITS = 64
) (
    input logic clk,
    input logic rst,
    input logic start,
    input logic stall,
    output logic load,
    output logic advance,
    output logic emit,
    output logic ready
);

    localparam int SETUP_STEPS = trivium_pkg::SETUP_ROUNDS / STEP_BITS;
    localparam int CNT_W = $clog2(SETUP_STEPS + 1);
    localparam logic [CNT_W-1:0] SETUP_LAST = CNT_W'(SETUP_STEPS - 1);

    // phase encodings.
    localparam logic [1:0] PH_IDLE = 2'd0;
    localparam logic [1:0] PH_SETUP = 2'd1;
    localparam logic [1:0] PH_GEN = 2'd2;

    logic [1:0] phase;
    logic [CNT_W-1:0] cnt;
    logic accept;
    logic run_gen;

    if (trivium_pkg::SETUP_ROUNDS % STEP_BITS != 0) begin : g_bad_step
        $error("trivium_ctrl: STEP_BITS must divide SETUP_ROUNDS");
    end

    assign ready = (phase != PH_SETUP);
    assign accept = start && ready && !stall;
    assign run_gen = (phase == PH_GEN) && !stall && !start;

    assign load = accept;
    assign advance = run_gen || ((phase == PH_SETUP) && !stall);
    assign emit = run_gen;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= PH_IDLE;
            cnt <= '0;
        end else if (accept) begin
            // also restarts a running cipher.
            phase <= PH_SETUP;
            cnt <= '0;
        end else if (phase == PH_SETUP && !stall) begin
            if (cnt == SETUP_LAST) begin
                phase <= PH_GEN;
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    a_cnt_in_range: assert property (
        @(posedge clk) disable iff (rst) cnt <= SETUP_LAST
    ) else $error("trivium_ctrl: setup counter past its last step");

    // words only after the last setup step.
    a_emit_in_gen: assert property (
        @(posedge clk) disable iff (rst)
        emit |-> (phase == PH_GEN)
            && ($past(phase) == PH_GEN || $past(cnt) == SETUP_LAST)
    ) else $error("trivium_ctrl: emit outside generate");

endmodule

// ==== hw/trivium_top.sv ====
`timescale 1ns/1ps

module trivium_top #(
    parameter int STEP_BITS = 64
) (
    input logic clk,
    input logic rst,
    input logic start,
    input logic stall,
    input trivium_pkg::key_t key,
    input trivium_pkg::iv_t iv,
    output logic [STEP_BITS-1:0] keystream,
    output logic keystream_valid,
    output logic ready
);

    logic load;
    logic advance;
    logic emit;
    trivium_pkg::trivium_state_u cur;
    trivium_pkg::trivium_state_u next_state;
    logic [STEP_BITS-1:0] z;

    trivium_ctrl #(
        .STEP_BITS(STEP_BITS)
    ) i_ctrl (
        .clk(clk),
        .rst(rst),
        .start(start),
        .stall(stall),
        .load(load),
        .advance(advance),
        .emit(emit),
        .ready(ready)
    );

    trivium_state #(
        .STEP_BITS(STEP_BITS)
    ) i_state (
        .clk(clk),
        .rst(rst),
        .load(load),
        .advance(advance),
        .emit(emit),
        .key(key),
        .iv(iv),
        .next_state(next_state),
        .z(z),
        .cur(cur),
        .keystream(keystream),
        .keystream_valid(keystream_valid)
    );

    // one step of STEP_BITS rounds per edge.
    trivium_round #(
        .STEP_BITS(STEP_BITS)
    ) i_round (
        .cur(cur),
        .next_state(next_state),
        .z(z)
    );

endmodule

// ==== bench/trivium_checks.svh ====
`ifndef TRIVIUM_CHECKS_SVH
`define TRIVIUM_CHECKS_SVH

// 17-bit fibonacci lfsr, taps 17 and 14.
function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
endfunction

// one lfsr step per bit taken.
task automatic take_bit(output logic b);
    b = lfsr_q[16];
    lfsr_q = lfsr_next(lfsr_q);
endtask

task automatic random_key(output trivium_pkg::key_t k);
    logic b;
    for (int i = 0; i < trivium_pkg::KEY_BITS; i++) begin
        take_bit(b);
        k[i] = b;
    end
endtask

task automatic check_word(
    input logic [STEP_BITS-1:0] got,
    input logic [STEP_BITS-1:0] exp,
    input string what
);
    checks++;
    if (got !== exp) begin
        errors++;
        test_errors++;
        $display("FAILED at %0t: %s: keystream %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_flags(
    input logic got_valid,
    input logic exp_valid,
    input logic got_ready,
    input logic exp_ready,
    input string what
);
    checks++;
    if (got_valid !== exp_valid || got_ready !== exp_ready) begin
        errors++;
        test_errors++;
        $display("FAILED at %0t: %s: valid %b ready %b, expected valid %b ready %b",
                 $time, what, got_valid, got_ready, exp_valid, exp_ready);
    end
endtask

// closes one test with its own line.
task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
        $display("%s: ok", name);
    end else begin
        tests_failed++;
        $display("%s: %0d errors", name, test_errors);
    end
    test_errors = 0;
endtask

`endif

// ==== bench/trivium_tb.sv ====
`timescale 1ns/1ps

module trivium_tb;

    localparam int STEP_BITS = 64;
    localparam int SETUP_STEPS = trivium_pkg::SETUP_ROUNDS / STEP_BITS;
    localparam int LATENCY = SETUP_STEPS + 1; // first word after the start edge.
    localparam int RESET_CYCLES = 16;
    localparam string PATTERN_FILE = "bench/trivium_patterns.txt";

    logic clk;
    logic rst;
    logic start;
    logic stall;
    trivium_pkg::key_t key;
    trivium_pkg::iv_t iv;
    logic [STEP_BITS-1:0] keystream;
    logic keystream_valid;
    logic ready;

    int checks;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;
    logic [16:0] lfsr_q;
    logic [STEP_BITS-1:0] model_word; // last word the consumer saw.
    bit model_known;
    bit loaded;

    int rec_kind[$];
    trivium_pkg::key_t rec_key[$];
    trivium_pkg::iv_t rec_iv[$];
    int rec_cnt[$];
    int rec_base[$];
    logic [STEP_BITS-1:0] exp_words[$];

    `include "trivium_checks.svh"

    trivium_top #(
        .STEP_BITS(STEP_BITS)
    ) i_trivium_top (
        .clk(clk),
        .rst(rst),
        .start(start),
        .stall(stall),
        .key(key),
        .iv(iv),
        .keystream(keystream),
        .keystream_valid(keystream_valid),
        .ready(ready)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // outputs are settled and inputs change 1 ns after the edge.
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // next value from the pattern file, comment lines skipped.
    task automatic read_value(input int fd, input bit hex, output logic [127:0] val,
                              output bit ok);
        string tok;
        string rest;
        int n;
        ok = 0;
        val = '0;
        while (!ok) begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1) return;
            if (tok.getc(0) == "#") begin
                n = $fgets(rest, fd);
            end else begin
                ok = 1;
            end
        end
        if (hex) n = $sscanf(tok, "%h", val);
        else n = $sscanf(tok, "%d", val);
        ok = (n == 1);
    endtask

    task automatic load_patterns();
        int fd;
        int cnt;
        bit ok;
        logic [127:0] val;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the pattern file %s", PATTERN_FILE);
            errors++;
            return;
        end
        while (1) begin
            read_value(fd, 0, val, ok);
            if (!ok) break;
            rec_kind.push_back(int'(val));
            read_value(fd, 1, val, ok);
            rec_key.push_back(val[trivium_pkg::KEY_BITS-1:0]);
            read_value(fd, 1, val, ok);
            rec_iv.push_back(val[trivium_pkg::IV_BITS-1:0]);
            read_value(fd, 0, val, ok);
            cnt = int'(val);
            rec_cnt.push_back(cnt);
            rec_base.push_back(exp_words.size());
            for (int j = 0; j < cnt; j++) begin
                read_value(fd, 1, val, ok);
                if (!ok) begin
                    $display("ERROR: pattern file ends inside record %0d", rec_kind.size() - 1);
                    errors++;
                    break;
                end
                exp_words.push_back(val[STEP_BITS-1:0]);
            end
        end
        $fclose(fd);
    endtask

    // runs a throwaway key into generate, so the next start is a restart.
    task automatic restart_prelude();
        trivium_pkg::key_t k;
        int guard;
        model_known = 0;
        random_key(k);
        key = k;
        random_key(k);
        iv = k;
        start = 1'b1;
        step();
        start = 1'b0;
        guard = 0;
        while (!keystream_valid && guard < 4 * LATENCY) begin
            step();
            guard++;
        end
        if (!keystream_valid) begin
            $display("ERROR: no keystream word came out for the first key of the restart test");
            errors++;
            test_errors++;
        end
        step();
        check_flags(keystream_valid, 1'b1, ready, 1'b1, "generate before restart");
    endtask

    task automatic run_record(input int idx);
        int kind;
        int base;
        int n;
        int w;
        logic stalled;
        logic exp_valid;
        trivium_pkg::key_t junk;
        string what;
        kind = rec_kind[idx];
        base = rec_base[idx];
        what = $sformatf("record %0d kind %0d", idx, kind);
        if (kind == 3) restart_prelude();
        start = 1'b1;
        stall = 1'b0;
        key = rec_key[idx];
        iv = rec_iv[idx];
        step();
        start = 1'b0;
        random_key(junk); // key only matters on the accepting edge.
        key = junk;
        n = 0;
        w = 0;
        check_flags(keystream_valid, 1'b0, ready, 1'b0, what);
        while (w < rec_cnt[idx]) begin
            stalled = 1'b0;
            if (kind == 2) take_bit(stalled);
            stall = stalled;
            start = (kind == 1 && n == SETUP_STEPS / 2);
            step();
            if (!stalled) n++;
            exp_valid = !stalled && n >= LATENCY;
            check_flags(keystream_valid, exp_valid, ready, n >= SETUP_STEPS, what);
            if (exp_valid) begin
                check_word(keystream, exp_words[base + w], what);
                model_word = exp_words[base + w];
                model_known = 1;
                w++;
            end else if (model_known) begin
                check_word(keystream, model_word, {what, " held word"});
            end
        end
        start = 1'b0;
        stall = 1'b0;
        finish_test(what);
    endtask

    initial begin : watchdog
        longint limit_cycles;
        wait (loaded);
        limit_cycles = RESET_CYCLES;
        foreach (rec_cnt[i]) limit_cycles += (SETUP_STEPS + rec_cnt[i]) * 4;
        #(limit_cycles * 10);
        $display("ERROR: simulation timed out after %0d clock periods", limit_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        rst = 1'b1;
        start = 1'b0;
        stall = 1'b0;
        key = '0;
        iv = '0;
        lfsr_q = 17'd78822;
        model_word = '0; // reset value of the word register.
        model_known = 1;
        load_patterns();
        if (rec_kind.size() == 0) begin
            $display("ERROR: the pattern file holds no test records");
            errors++;
        end
        loaded = 1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flags(keystream_valid, 1'b0, ready, 1'b1, "reset");
        check_word(keystream, '0, "reset");
        finish_test("reset");
        foreach (rec_kind[i]) run_record(i);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== bench/trivium_patterns.txt ====
# kind key iv words, then one expected keystream word per line, hex, bit 0 earliest
# kind 0 plain run, 1 start during setup, 2 random stall, 3 restart during generate
0 00000000000000000000 00000000000000000000 4
1b05595826bfe0fb
7fc99f234e2e7a51
2dcf071916033256
cde9b2a10f79a8e7
1 00000000000000000000 00000000000000000000 4
1b05595826bfe0fb
7fc99f234e2e7a51
2dcf071916033256
cde9b2a10f79a8e7
2 00000000000000000000 00000000000000000000 4
1b05595826bfe0fb
7fc99f234e2e7a51
2dcf071916033256
cde9b2a10f79a8e7
3 00000000000000000000 00000000000000000000 4
1b05595826bfe0fb
7fc99f234e2e7a51
2dcf071916033256
cde9b2a10f79a8e7

// ==== flist.f ====
+incdir+bench
hw/trivium_pkg.sv
hw/trivium_round.sv
hw/trivium_state.sv
hw/trivium_ctrl.sv
hw/trivium_top.sv
bench/trivium_tb.sv
